//--- vlog.f
verilog/bus_pkg.sv
verilog/bus_axi_bridge.sv
verilog/bus_core_timer.sv
verilog/bus_load_router.sv
verilog/bus_top.sv
test/tb_clock_gen.sv
test/tb_axi_mem.sv
test/tb_bus.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_bus \
  -f vlog.f --Mdir obj_dir -o tb_bus_sim
./obj_dir/tb_bus_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- test/tb_bus.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bus;

  localparam int N_STORE = 24;
  localparam int N_FETCH = 16;
  localparam int N_PAIR  = 8;
  localparam int N_TIMER = 8;
  localparam int N_RAW   = 4;  // store and load raised together
  localparam int N_OPS   = 2 * N_STORE + N_FETCH + 2 * N_PAIR + N_TIMER + 2 * N_RAW;
  localparam int LIMIT   = N_OPS * 20;

  logic                clk;
  logic                rst;
  logic                slow;
  bus_pkg::fetch_req_t fetch_req;
  bus_pkg::load_req_t  load_req;
  bus_pkg::store_req_t store_req;
  bus_pkg::rd_rsp_t    fetch_rsp;
  bus_pkg::rd_rsp_t    load_rsp;
  logic                store_done;
  bus_pkg::axi_ar_t    axi_ar;
  bus_pkg::axi_aw_t    axi_aw;
  bus_pkg::axi_w_t     axi_w;
  bus_pkg::axi_r_t     axi_r;
  logic                arready;
  logic                awready;
  logic                wready;
  logic                bvalid;

  logic [31:0]         lfsr;
  logic [7:0]          mirror [0:2047];
  logic [63:0]         cyc;  // cycles since reset release
  int                  cycles;
  int                  errors;
  int                  checks;

  tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

  bus_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req),
    .fetch_rsp_o   (fetch_rsp),
    .load_req_i    (load_req),
    .load_rsp_o    (load_rsp),
    .store_req_i   (store_req),
    .store_done_o  (store_done),
    .axi_ar_o      (axi_ar),
    .axi_aw_o      (axi_aw),
    .axi_w_o       (axi_w),
    .axi_arready_i (arready),
    .axi_awready_i (awready),
    .axi_wready_i  (wready),
    .axi_r_i       (axi_r),
    .axi_bvalid_i  (bvalid)
  );

  tb_axi_mem u_mem (
    .clk           (clk),
    .rst           (rst),
    .slow_i        (slow),
    .axi_ar_i      (axi_ar),
    .axi_aw_i      (axi_aw),
    .axi_w_i       (axi_w),
    .axi_arready_o (arready),
    .axi_awready_o (awready),
    .axi_wready_o  (wready),
    .axi_r_o       (axi_r),
    .axi_bvalid_o  (bvalid)
  );

  always @(posedge clk) begin
    if (rst) cyc <= 64'd0;
    else cyc <= cyc + 64'd1;
  end

  initial cycles = 0;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'd0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // log2 of the number of bytes enabled
  function automatic logic [2:0] access_size(input logic [7:0] strb);
    case ($countones(strb))
      1:       return 3'd0;
      2:       return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  function automatic logic [31:0] mirror_word(input logic [10:0] a);
    return {mirror[{a[10:2], 2'd3}], mirror[{a[10:2], 2'd2}],
            mirror[{a[10:2], 2'd1}], mirror[{a[10:2], 2'd0}]};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #1;
  endtask

  task automatic rand_store(output bus_pkg::store_req_t req);
    logic [1:0]  sz;
    logic [10:0] a;
    logic [3:0]  strb;
    sz = 2'(rand_bits(2));
    a  = 11'(rand_bits(11));
    case (sz)
      2'd0: strb = 4'h1;
      2'd1: begin
        strb = 4'h3;
        a[0] = 1'b0;
      end
      default: begin
        strb   = 4'hf;
        a[1:0] = 2'b00;
      end
    endcase
    req = '{addr: {21'd0, a}, data: rand_bits(32), strb: {4'h0, strb}, valid: 1'b1};
  endtask

  task automatic update_mirror(input bus_pkg::store_req_t req);
    for (int b = 0; b < 4; b++) begin
      if (req.strb[b]) mirror[req.addr[10:0] + 11'(b)] = req.data[8*b +: 8];
    end
  endtask

  task automatic do_store(input bus_pkg::store_req_t req);
    store_req = req;
    do begin
      @(negedge clk);
      if (axi_aw.valid) begin
        check("axi_aw_o.size", {29'd0, access_size(req.strb)}, {29'd0, axi_aw.size});
      end
    end while (!store_done);
    update_mirror(req);
    next_drive();
    store_req = '0;
  endtask

  task automatic do_load(input logic [10:0] a);
    load_req = '{addr: {21'd0, a[10:2], 2'b00}, strb: 8'h0f, valid: 1'b1};
    do begin
      @(negedge clk);
      if (axi_ar.valid) check("axi_ar_o.size", 32'd2, {29'd0, axi_ar.size});  // word
    end while (!load_rsp.valid);
    check("load_rsp_o.data", mirror_word(a), load_rsp.data);
    next_drive();
    load_req = '0;
  endtask

  task automatic do_fetch(input logic [10:0] a);
    fetch_req = '{addr: {21'd0, a[10:2], 2'b00}, valid: 1'b1};
    do begin
      @(negedge clk);
      if (axi_ar.valid) check("axi_ar_o.size", 32'd2, {29'd0, axi_ar.size});
    end while (!fetch_rsp.valid);
    check("fetch_rsp_o.data", mirror_word(a), fetch_rsp.data);
    next_drive();
    fetch_req = '0;
  endtask

  // load wins arbitration over fetch
  task automatic fetch_load_pair();
    logic [10:0] fa;
    logic [10:0] la;
    logic        f_seen;
    logic        l_seen;
    fa        = 11'(rand_bits(11));
    la        = 11'(rand_bits(11));
    f_seen    = 1'b0;
    l_seen    = 1'b0;
    fetch_req = '{addr: {21'd0, fa[10:2], 2'b00}, valid: 1'b1};
    load_req  = '{addr: {21'd0, la[10:2], 2'b00}, strb: 8'h0f, valid: 1'b1};
    while (!(f_seen && l_seen)) begin
      @(negedge clk);
      if (load_rsp.valid) begin
        if (f_seen) begin
          errors++;
          $display("the fetch response came before the load response");
        end
        check("load_rsp_o.data", mirror_word(la), load_rsp.data);
        l_seen = 1'b1;
      end
      if (fetch_rsp.valid) begin
        check("fetch_rsp_o.data", mirror_word(fa), fetch_rsp.data);
        f_seen = 1'b1;
      end
      next_drive();
      if (l_seen) load_req = '0;
      if (f_seen) fetch_req = '0;
    end
  endtask

  task automatic timer_load(input logic hi);
    logic [63:0] t;
    load_req = '{addr: hi ? bus_pkg::TIMER_ADDR_HI : bus_pkg::TIMER_ADDR_LO,
                 strb: 8'h0f, valid: 1'b1};
    @(negedge clk);
    t = cyc;  // request cycle
    check("load_rsp_o.valid", 32'd0, {31'd0, load_rsp.valid});
    @(negedge clk);
    check("load_rsp_o.valid", 32'd1, {31'd0, load_rsp.valid});
    check("axi_ar_o.valid", 32'd0, {31'd0, axi_ar.valid});
    check("load_rsp_o.data", hi ? t[63:32] : t[31:0], load_rsp.data);
    next_drive();
    load_req = '0;
  endtask

  task automatic store_then_load();
    bus_pkg::store_req_t req;
    logic                d_seen;
    logic                l_seen;
    rand_store(req);
    d_seen    = 1'b0;
    l_seen    = 1'b0;
    slow      = 1'b1;
    store_req = req;
    load_req  = '{addr: {req.addr[31:2], 2'b00}, strb: 8'h0f, valid: 1'b1};
    while (!(d_seen && l_seen)) begin
      @(negedge clk);
      if (store_done) begin
        update_mirror(req);
        d_seen = 1'b1;
      end
      if (load_rsp.valid) begin
        if (!d_seen) begin
          errors++;
          $display("the load response came before the store completed");
        end
        check("load_rsp_o.data", mirror_word(req.addr[10:0]), load_rsp.data);
        l_seen = 1'b1;
      end
      next_drive();
      if (d_seen) store_req = '0;
      if (l_seen) load_req = '0;
    end
    slow = 1'b0;
  endtask

  initial begin
    bus_pkg::store_req_t req;
    logic [10:0]         ab;
    fetch_req = '0;
    load_req  = '0;
    store_req = '0;
    slow      = 1'b0;
    errors    = 0;
    checks    = 0;
    lfsr      = 32'hd6c2_1ba3;
    for (int a = 0; a < 2048; a++) begin
      ab         = 11'(a);
      mirror[ab] = ab[7:0] ^ {5'd0, ab[10:8]} ^ 8'h5a;  // same fill as the slave
    end

    wait (rst === 1'b0);
    next_drive();

    for (int n = 0; n < N_STORE; n++) begin
      rand_store(req);
      do_store(req);
      do_load(req.addr[10:0]);
    end
    for (int n = 0; n < N_FETCH; n++) begin
      do_fetch(11'(rand_bits(11)));
    end
    for (int n = 0; n < N_PAIR; n++) begin
      fetch_load_pair();
    end
    for (int n = 0; n < N_TIMER; n++) begin
      timer_load(1'(rand_bits(1)));
    end
    for (int n = 0; n < N_RAW; n++) begin
      store_then_load();
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   slow_i,  // adds 4 cycles to every delay
  input  wire bus_pkg::axi_ar_t axi_ar_i,
  input  wire bus_pkg::axi_aw_t axi_aw_i,
  input  wire bus_pkg::axi_w_t  axi_w_i,
  output logic                  axi_arready_o,
  output logic                  axi_awready_o,
  output logic                  axi_wready_o,
  output bus_pkg::axi_r_t       axi_r_o,
  output logic                  axi_bvalid_o
);

  logic [63:0] mem [0:255];
  logic [31:0] lfsr;
  logic [2:0]  ar_cnt;
  logic [2:0]  aw_cnt;
  logic [2:0]  w_cnt;
  logic [1:0]  ar_dly;
  logic [1:0]  aw_dly;
  logic [1:0]  w_dly;
  logic [2:0]  r_wait;
  logic [2:0]  b_wait;
  logic        r_pend;
  logic        b_pend;
  logic        aw_got;
  logic        w_got;
  logic [7:0]  rd_idx;
  logic [7:0]  wr_idx;
  logic [63:0] wr_data;
  logic [7:0]  wr_strb;
  int          i;

  initial lfsr = 32'hd6c2_1ba3;

  function automatic logic [1:0] next_delay();
    logic       fb;
    logic [1:0] d;
    d = 2'b00;
    repeat (2) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      d    = {d[0], fb};
    end
    return d;
  endfunction

  // byte value depends on all 11 address bits
  function automatic logic [63:0] fill_word(input int idx);
    logic [63:0] w;
    logic [10:0] a;
    for (int k = 0; k < 8; k++) begin
      a          = 11'(idx * 8 + k);
      w[8*k +: 8] = a[7:0] ^ {5'd0, a[10:8]} ^ 8'h5a;
    end
    return w;
  endfunction

  function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] data,
                                        input logic [7:0] strb);
    logic [63:0] w;
    w = old;
    for (int k = 0; k < 8; k++) begin
      if (strb[k]) begin
        w[8*k +: 8] = data[8*k +: 8];
      end
    end
    return w;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (i = 0; i < 256; i++) begin
        mem[i] <= fill_word(i);
      end
      axi_arready_o <= 1'b0;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_r_o       <= '0;
      axi_bvalid_o  <= 1'b0;
      {ar_cnt, aw_cnt, w_cnt} <= '0;
      {ar_dly, aw_dly, w_dly} <= '0;
      {r_pend, b_pend, aw_got, w_got} <= '0;
    end else begin
      if (axi_ar_i.valid & axi_arready_o) begin
        axi_arready_o <= 1'b0;
        ar_cnt        <= 3'd0;
        ar_dly        <= next_delay();
        rd_idx        <= axi_ar_i.addr[10:3];
        r_wait        <= {slow_i, next_delay()};
        r_pend        <= 1'b1;
      end else if (axi_ar_i.valid) begin
        if (ar_cnt >= {slow_i, ar_dly}) axi_arready_o <= 1'b1;
        else ar_cnt <= ar_cnt + 3'd1;
      end

      axi_r_o.valid <= 1'b0;  // one cycle pulse
      if (r_pend) begin
        if (r_wait == 3'd0) begin
          axi_r_o <= '{data: mem[rd_idx], valid: 1'b1};
          r_pend  <= 1'b0;
        end else begin
          r_wait <= r_wait - 3'd1;
        end
      end

      if (axi_aw_i.valid & axi_awready_o) begin
        axi_awready_o <= 1'b0;
        aw_cnt        <= 3'd0;
        aw_dly        <= next_delay();
        aw_got        <= 1'b1;
        wr_idx        <= axi_aw_i.addr[10:3];
      end else if (axi_aw_i.valid & ~aw_got) begin
        if (aw_cnt >= {slow_i, aw_dly}) axi_awready_o <= 1'b1;
        else aw_cnt <= aw_cnt + 3'd1;
      end

      if (axi_w_i.valid & axi_wready_o) begin
        axi_wready_o <= 1'b0;
        w_cnt        <= 3'd0;
        w_dly        <= next_delay();
        w_got        <= 1'b1;
        wr_data      <= axi_w_i.data;
        wr_strb      <= axi_w_i.strb;
      end else if (axi_w_i.valid & ~w_got) begin
        if (w_cnt >= {slow_i, w_dly}) axi_wready_o <= 1'b1;
        else w_cnt <= w_cnt + 3'd1;
      end

      // both halves in, commit then respond
      if (aw_got & w_got) begin
        mem[wr_idx] <= merge(mem[wr_idx], wr_data, wr_strb);
        aw_got      <= 1'b0;
        w_got       <= 1'b0;
        b_pend      <= 1'b1;
        b_wait      <= {slow_i, next_delay()};
      end

      axi_bvalid_o <= 1'b0;
      if (b_pend) begin
        if (b_wait == 3'd0) begin
          axi_bvalid_o <= 1'b1;
          b_pend       <= 1'b0;
        end else begin
          b_wait <= b_wait - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog/bus_top.sv
`timescale 1ns/100ps
`default_nettype none

module bus_top (
  input  wire                      clk,
  input  wire                      rst,
  // core ports
  input  wire bus_pkg::fetch_req_t fetch_req_i,
  output bus_pkg::rd_rsp_t         fetch_rsp_o,
  input  wire bus_pkg::load_req_t  load_req_i,
  output bus_pkg::rd_rsp_t         load_rsp_o,
  input  wire bus_pkg::store_req_t store_req_i,
  output logic                     store_done_o,
  // axi master
  output bus_pkg::axi_ar_t         axi_ar_o,
  output bus_pkg::axi_aw_t         axi_aw_o,
  output bus_pkg::axi_w_t          axi_w_o,
  input  wire                      axi_arready_i,
  input  wire                      axi_awready_i,
  input  wire                      axi_wready_i,
  input  wire bus_pkg::axi_r_t     axi_r_i,
  input  wire                      axi_bvalid_i
);

  bus_pkg::load_req_t bridge_load;
  bus_pkg::rd_rsp_t   bridge_rsp;
  bus_pkg::rd_rsp_t   timer_rsp;
  logic               timer_valid;
  logic               timer_hi;

  bus_load_router u_router (
    .load_i        (load_req_i),
    .bridge_load_o (bridge_load),
    .timer_valid_o (timer_valid),
    .timer_hi_o    (timer_hi),
    .bridge_rsp_i  (bridge_rsp),
    .timer_rsp_i   (timer_rsp),
    .load_rsp_o    (load_rsp_o)
  );

  bus_axi_bridge u_bridge (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_req_i),
    .load_i        (bridge_load),
    .store_i       (store_req_i),
    .fetch_rsp_o   (fetch_rsp_o),
    .load_rsp_o    (bridge_rsp),
    .store_done_o  (store_done_o),
    .axi_ar_o      (axi_ar_o),
    .axi_aw_o      (axi_aw_o),
    .axi_w_o       (axi_w_o),
    .axi_arready_i (axi_arready_i),
    .axi_awready_i (axi_awready_i),
    .axi_wready_i  (axi_wready_i),
    .axi_r_i       (axi_r_i),
    .axi_bvalid_i  (axi_bvalid_i)
  );

  bus_core_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .rd_valid_i (timer_valid),
    .rd_hi_i    (timer_hi),
    .rsp_o      (timer_rsp)
  );

endmodule

`default_nettype wire

//--- verilog/bus_load_router.sv
`timescale 1ns/100ps
`default_nettype none

module bus_load_router (
  input  wire bus_pkg::load_req_t load_i,
  output bus_pkg::load_req_t      bridge_load_o,
  output logic                    timer_valid_o,
  output logic                    timer_hi_o,
  input  wire bus_pkg::rd_rsp_t   bridge_rsp_i,
  input  wire bus_pkg::rd_rsp_t   timer_rsp_i,
  output bus_pkg::rd_rsp_t        load_rsp_o
);

  logic hit_lo;
  logic hit_hi;
  logic timer_hit;

  // address decode
  assign hit_lo    = load_i.addr == bus_pkg::TIMER_ADDR_LO;
  assign hit_hi    = load_i.addr == bus_pkg::TIMER_ADDR_HI;
  assign timer_hit = hit_lo | hit_hi;

  assign timer_valid_o = load_i.valid & timer_hit;
  assign timer_hi_o    = hit_hi;

  // everything else goes out on axi
  always_comb begin
    bridge_load_o       = load_i;
    bridge_load_o.valid = load_i.valid & ~timer_hit;
  end

  // only one side answers at a time
  always_comb begin
    load_rsp_o.valid = bridge_rsp_i.valid | timer_rsp_i.valid;
    load_rsp_o.data  = ({bus_pkg::DATA_W{bridge_rsp_i.valid}} & bridge_rsp_i.data) |
                       ({bus_pkg::DATA_W{timer_rsp_i.valid}} & timer_rsp_i.data);
  end

endmodule

`default_nettype wire

//--- verilog/bus_core_timer.sv
`timescale 1ns/100ps
`default_nettype none

module bus_core_timer (
  input  wire              clk,
  input  wire              rst,
  input  wire              rd_valid_i,
  input  wire              rd_hi_i,
  output bus_pkg::rd_rsp_t rsp_o
);

  logic [63:0]                mtime;
  logic [bus_pkg::DATA_W-1:0] rd_data_q;
  logic                       rd_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      mtime      <= mtime + 64'd1;
      // request stays up through the response cycle, answer once
      rd_valid_q <= rd_valid_i & ~rd_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid_i) begin
      rd_data_q <= rd_hi_i ? mtime[63:32] : mtime[31:0];  // value at request cycle
    end
  end

  assign rsp_o = '{data: rd_data_q, valid: rd_valid_q};

endmodule

`default_nettype wire

//--- verilog/bus_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module bus_axi_bridge (
  input  wire                      clk,
  input  wire                      rst,
  input  wire bus_pkg::fetch_req_t fetch_i,
  input  wire bus_pkg::load_req_t  load_i,
  input  wire bus_pkg::store_req_t store_i,
  output bus_pkg::rd_rsp_t         fetch_rsp_o,
  output bus_pkg::rd_rsp_t         load_rsp_o,
  output logic                     store_done_o,
  output bus_pkg::axi_ar_t         axi_ar_o,
  output bus_pkg::axi_aw_t         axi_aw_o,
  output bus_pkg::axi_w_t          axi_w_o,
  input  wire                      axi_arready_i,
  input  wire                      axi_awready_i,
  input  wire                      axi_wready_i,
  input  wire bus_pkg::axi_r_t     axi_r_i,
  input  wire                      axi_bvalid_i
);

  typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR, WR_RESP} state_t;

  state_t                         state_q;
  logic                           aw_done_q;
  logic                           w_done_q;

  // latched transaction
  logic [bus_pkg::ADDR_W-1:0]     addr_q;
  logic [2:0]                     size_q;
  logic                           fetch_q;  // read belongs to fetch port
  logic [bus_pkg::AXI_DATA_W-1:0] wdata_q;
  logic [7:0]                     wstrb_q;

  logic [bus_pkg::DATA_W-1:0]     st_data_sh;
  logic [3:0]                     st_strb_sh;
  bus_pkg::axi_data_u             st_word;
  logic [7:0]                     st_strb;
  bus_pkg::axi_data_u             rd_word;
  logic [bus_pkg::DATA_W-1:0]     rd_lane;
  logic                           aw_fire;
  logic                           w_fire;

  function automatic logic [2:0] size_of(input logic [7:0] strb);
    case (strb)
      8'h01:   size_of = 3'd0;
      8'h03:   size_of = 3'd1;
      default: size_of = 3'd2;  // word
    endcase
  endfunction

  // store lane placement
  always_comb begin
    st_data_sh      = store_i.data << {store_i.addr[1:0], 3'b000};
    st_strb_sh      = store_i.strb[3:0] << store_i.addr[1:0];
    st_word.lane.hi = st_data_sh;  // same data on both lanes
    st_word.lane.lo = st_data_sh;
    st_strb         = store_i.addr[2] ? {st_strb_sh, 4'h0} : {4'h0, st_strb_sh};
  end

  assign aw_fire = axi_aw_o.valid & axi_awready_i;
  assign w_fire  = axi_w_o.valid & axi_wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (store_i.valid) begin
            state_q <= WR;
          end else if (load_i.valid | fetch_i.valid) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (axi_arready_i) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (axi_r_i.valid) begin
            state_q <= IDLE;
          end
        end
        WR: begin
          // aw and w may complete in either order
          if (aw_fire) begin
            aw_done_q <= 1'b1;
          end
          if (w_fire) begin
            w_done_q <= 1'b1;
          end
          if ((aw_done_q | aw_fire) & (w_done_q | w_fire)) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (axi_bvalid_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // store > load > fetch
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      if (store_i.valid) begin
        addr_q  <= store_i.addr;
        size_q  <= size_of(store_i.strb);
        wdata_q <= st_word.raw;
        wstrb_q <= st_strb;
      end else if (load_i.valid) begin
        addr_q  <= load_i.addr;
        size_q  <= size_of(load_i.strb);
        fetch_q <= 1'b0;
      end else if (fetch_i.valid) begin
        addr_q  <= fetch_i.addr;
        size_q  <= 3'd2;
        fetch_q <= 1'b1;
      end
    end
  end

  assign axi_ar_o = '{addr: addr_q, size: size_q, valid: state_q == RD_ADDR};
  assign axi_aw_o = '{addr: addr_q, size: size_q, valid: (state_q == WR) & ~aw_done_q};
  assign axi_w_o  = '{data: wdata_q, strb: wstrb_q, valid: (state_q == WR) & ~w_done_q};

  // read lane by addr bit 2
  assign rd_word = axi_r_i.data;
  assign rd_lane = addr_q[2] ? rd_word.lane.hi : rd_word.lane.lo;

  assign fetch_rsp_o = '{
    data:  rd_lane,
    valid: (state_q == RD_DATA) & fetch_q & axi_r_i.valid
  };
  assign load_rsp_o = '{
    data:  rd_lane,
    valid: (state_q == RD_DATA) & ~fetch_q & axi_r_i.valid
  };

  assign store_done_o = (state_q == WR_RESP) & axi_bvalid_i;

endmodule

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;

  // machine timer words, clint layout
  localparam logic [ADDR_W-1:0] TIMER_ADDR_LO = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] TIMER_ADDR_HI = 32'h0200_bffc;

  // core side
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              valid;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        strb;  // 1, 3 or f for byte, half, word
    logic              valid;
  } load_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;  // unshifted, low bytes
    logic [7:0]        strb;
    logic              valid;
  } store_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              valid;
  } rd_rsp_t;

  // axi side, single beat
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic              valid;
  } axi_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic              valid;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [7:0]            strb;
    logic                  valid;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic                  valid;
  } axi_r_t;

  // bus word as raw bits or as two 32-bit lanes
  typedef union packed {
    logic [AXI_DATA_W-1:0] raw;
    struct packed {
      logic [DATA_W-1:0] hi;
      logic [DATA_W-1:0] lo;
    } lane;
  } axi_data_u;

endpackage

`default_nettype wire
